//--- sim.f
common/corePkg.sv
src/fetch/fetchStage.sv
src/decode/regFile.sv
src/decode/decodeStage.sv
src/execute/alu.sv
src/execute/executeStage.sv
src/writebackStage.sv
src/mipsCore.sv
sim/mipsCoreTb_sva.sv
sim/mipsCoreTb.sv

//--- Bender.yml
package:
  name: mips_core

sources:
  - common/corePkg.sv
  - src/fetch/fetchStage.sv
  - src/decode/regFile.sv
  - src/decode/decodeStage.sv
  - src/execute/alu.sv
  - src/execute/executeStage.sv
  - src/writebackStage.sv
  - src/mipsCore.sv
  - target: simulation
    files:
      - sim/mipsCoreTb_sva.sv
      - sim/mipsCoreTb.sv

//--- sim/mipsCoreTb.sv
module mipsCoreTb;

    localparam corePkg::word_t ResetPc = 32'hBFC00000;
    localparam int ProgWords     = 33;
    localparam int TraceLen      = 21;
    localparam int TimeoutCycles = (ProgWords + TraceLen) * 4 + 200;

    typedef struct packed {
        corePkg::word_t    pc;
        corePkg::regAddr_t dest;
        corePkg::word_t    value;
    } traceEntry_t;

    logic              clk = 1'b0;
    logic              reset;
    logic              instStall;
    corePkg::word_t    instr;
    corePkg::word_t    instAddr;
    corePkg::word_t    tracePc;
    logic [3:0]        traceEn;
    corePkg::regAddr_t traceNum;
    corePkg::word_t    traceData;

    corePkg::word_t progMem [ProgWords];
    traceEntry_t    expTrace [TraceLen];
    integer         seed;
    int             matched;

    mipsCore #(
        .ResetPc (ResetPc)
    ) mipsCore_inst (
        .clk              (clk),
        .reset_i          (reset),
        .instAddr_o       (instAddr),
        .instr_i          (instr),
        .instStall_i      (instStall),
        .debugWbPc_o      (tracePc),
        .debugWbRfWen_o   (traceEn),
        .debugWbRfWnum_o  (traceNum),
        .debugWbRfWdata_o (traceData)
    );

    always #5 clk = ~clk;

    function automatic corePkg::word_t encodeR(
        input logic [5:0]        funct,
        input corePkg::regAddr_t rs,
        input corePkg::regAddr_t rt,
        input corePkg::regAddr_t rd,
        input corePkg::regAddr_t shamt
    );
        return {corePkg::OpSpecial, rs, rt, rd, shamt, funct};
    endfunction

    function automatic corePkg::word_t encodeI(
        input logic [5:0]        op,
        input corePkg::regAddr_t rs,
        input corePkg::regAddr_t rt,
        input logic [15:0]       imm
    );
        return {op, rs, rt, imm};
    endfunction

    function automatic corePkg::word_t encodeJ(input corePkg::word_t target);
        return {corePkg::OpJ, target[27:2]};
    endfunction

    // unlisted or undefined addresses read as sll $0,$0,0
    function automatic corePkg::word_t fetchWord(input corePkg::word_t addr);
        corePkg::word_t offset;
        offset = addr - ResetPc;
        if (offset < ProgWords * 4) begin
            return progMem[offset[31:2]];
        end else begin
            return 32'h0000_0000;
        end
    endfunction

    task automatic loadProgram();
        for (int i = 0; i < ProgWords; i++) begin
            progMem[i] = 32'h0000_0000;
        end
        progMem[0]  = encodeI(corePkg::OpAddiu, 5'd0, 5'd1, 16'h0007);
        progMem[1]  = encodeI(corePkg::OpAddiu, 5'd1, 5'd2, 16'hFFFD);   // negative imm
        progMem[2]  = encodeR(corePkg::FnAddu, 5'd1, 5'd2, 5'd3, 5'd0);
        progMem[3]  = encodeR(corePkg::FnSubu, 5'd2, 5'd3, 5'd4, 5'd0);
        progMem[4]  = encodeR(corePkg::FnSlt, 5'd4, 5'd1, 5'd5, 5'd0);
        progMem[5]  = encodeR(corePkg::FnSlt, 5'd1, 5'd4, 5'd6, 5'd0);
        progMem[6]  = encodeI(corePkg::OpLui, 5'd0, 5'd7, 16'h8001);
        progMem[7]  = encodeI(corePkg::OpOri, 5'd7, 5'd7, 16'hF0F0);
        progMem[8]  = encodeI(corePkg::OpAndi, 5'd7, 5'd8, 16'hFF00);   // zero extended
        progMem[9]  = encodeI(corePkg::OpAddiu, 5'd0, 5'd9, 16'hFF00);  // sign extended
        progMem[10] = encodeR(corePkg::FnXor, 5'd9, 5'd8, 5'd10, 5'd0);
        progMem[11] = encodeR(corePkg::FnAnd, 5'd10, 5'd7, 5'd11, 5'd0);
        progMem[12] = encodeR(corePkg::FnOr, 5'd11, 5'd1, 5'd12, 5'd0);
        progMem[13] = encodeR(corePkg::FnSll, 5'd0, 5'd12, 5'd13, 5'd4);
        progMem[14] = encodeI(corePkg::OpAddiu, 5'd1, 5'd0, 16'h0005);   // write to $0
        progMem[15] = encodeR(corePkg::FnAddu, 5'd0, 5'd1, 5'd14, 5'd0);
        progMem[16] = encodeI(corePkg::OpBeq, 5'd1, 5'd14, 16'h0002);    // taken
        progMem[17] = encodeI(corePkg::OpAddiu, 5'd0, 5'd15, 16'h0001);
        progMem[18] = encodeI(corePkg::OpAddiu, 5'd0, 5'd16, 16'h0BAD);
        progMem[19] = encodeI(corePkg::OpBne, 5'd1, 5'd14, 16'h0005);    // not taken
        progMem[20] = encodeI(corePkg::OpAddiu, 5'd0, 5'd17, 16'h0002);
        progMem[21] = encodeI(corePkg::OpAddiu, 5'd0, 5'd18, 16'h0003);
        progMem[22] = encodeI(corePkg::OpBne, 5'd15, 5'd0, 16'h0003);    // taken
        progMem[23] = encodeI(corePkg::OpAddiu, 5'd0, 5'd19, 16'h0004);
        progMem[24] = encodeI(corePkg::OpAddiu, 5'd0, 5'd16, 16'h0BAD);
        progMem[25] = encodeI(corePkg::OpAddiu, 5'd0, 5'd16, 16'h0BAD);
        progMem[26] = encodeJ(ResetPc + 32'h80);
        progMem[27] = encodeI(corePkg::OpAddiu, 5'd0, 5'd20, 16'h0005);
        progMem[28] = encodeI(corePkg::OpAddiu, 5'd0, 5'd16, 16'h0BAD);
        progMem[32] = encodeR(corePkg::FnAddu, 5'd20, 5'd19, 5'd21, 5'd0);
    endtask

    // one entry per commit with pc, destination and value
    task automatic loadTrace();
        expTrace[0]  = '{ResetPc + 32'h00, 5'd1, 32'h0000_0007};
        expTrace[1]  = '{ResetPc + 32'h04, 5'd2, 32'h0000_0004};
        expTrace[2]  = '{ResetPc + 32'h08, 5'd3, 32'h0000_000B};
        expTrace[3]  = '{ResetPc + 32'h0C, 5'd4, 32'hFFFF_FFF9};
        expTrace[4]  = '{ResetPc + 32'h10, 5'd5, 32'h0000_0001};
        expTrace[5]  = '{ResetPc + 32'h14, 5'd6, 32'h0000_0000};
        expTrace[6]  = '{ResetPc + 32'h18, 5'd7, 32'h8001_0000};
        expTrace[7]  = '{ResetPc + 32'h1C, 5'd7, 32'h8001_F0F0};
        expTrace[8]  = '{ResetPc + 32'h20, 5'd8, 32'h0000_F000};
        expTrace[9]  = '{ResetPc + 32'h24, 5'd9, 32'hFFFF_FF00};
        expTrace[10] = '{ResetPc + 32'h28, 5'd10, 32'hFFFF_0F00};
        expTrace[11] = '{ResetPc + 32'h2C, 5'd11, 32'h8001_0000};
        expTrace[12] = '{ResetPc + 32'h30, 5'd12, 32'h8001_0007};
        expTrace[13] = '{ResetPc + 32'h34, 5'd13, 32'h0010_0070};
        expTrace[14] = '{ResetPc + 32'h3C, 5'd14, 32'h0000_0007};  // $0 still zero
        expTrace[15] = '{ResetPc + 32'h44, 5'd15, 32'h0000_0001};  // beq delay slot
        expTrace[16] = '{ResetPc + 32'h50, 5'd17, 32'h0000_0002};
        expTrace[17] = '{ResetPc + 32'h54, 5'd18, 32'h0000_0003};
        expTrace[18] = '{ResetPc + 32'h5C, 5'd19, 32'h0000_0004};  // bne delay slot
        expTrace[19] = '{ResetPc + 32'h6C, 5'd20, 32'h0000_0005};  // j delay slot
        expTrace[20] = '{ResetPc + 32'h80, 5'd21, 32'h0000_0009};
    endtask

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkWord(input corePkg::word_t actual, input corePkg::word_t expected,
                             input string what);
        if (actual !== expected) begin
            stopWithFailure($sformatf("FAILED at time %0t: %s is %h, expected %h",
                                      $time, what, actual, expected));
        end
    endtask

    task automatic checkReg(input corePkg::regAddr_t actual, input corePkg::regAddr_t expected,
                            input string what);
        if (actual !== expected) begin
            stopWithFailure($sformatf("FAILED at time %0t: %s is %0d, expected %0d",
                                      $time, what, actual, expected));
        end
    endtask

    task automatic driveStall();
        integer draw;
        draw      = $random(seed);
        instStall = (draw[1:0] == 2'b00);   // roughly one cycle in four
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;
        driveStall();
    endtask

    // instruction memory answers the address of the current cycle
    always @(posedge clk) begin
        #1;
        instr <= fetchWord(instAddr);
    end

    initial begin
        repeat (TimeoutCycles) @(posedge clk);
        stopWithFailure("Timeout: the commit trace did not complete in the allowed cycles");
    end

    initial begin
        seed      = 51515;
        reset     = 1'b1;
        instStall = 1'b0;
        instr     = '0;
        matched   = 0;
        loadProgram();
        loadTrace();
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        driveStall();
        checkWord(instAddr, ResetPc, "first fetch address");
        while (matched < TraceLen) begin
            @(negedge clk);
            if (traceEn != 4'b0) begin
                checkWord(tracePc, expTrace[matched].pc,
                          $sformatf("pc of entry %0d", matched));
                checkReg(traceNum, expTrace[matched].dest,
                         $sformatf("reg of entry %0d", matched));
                checkWord(traceData, expTrace[matched].value,
                          $sformatf("data of entry %0d", matched));
                matched++;
            end
            nextCycle();
        end
        repeat (20) begin
            @(negedge clk);
            if (traceEn != 4'b0) begin
                stopWithFailure("An extra trace entry appeared after the last expected one");
            end
            nextCycle();
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- sim/mipsCoreTb_sva.sv
module mipsCoreTb_sva #(
    parameter corePkg::word_t ResetPc = 32'hBFC00000
) (
    input logic              clk,
    input logic              reset_i,
    input logic              stall_i,
    input corePkg::word_t    instAddr_i,
    input logic [3:0]        traceEn_i,
    input corePkg::word_t    tracePc_i,
    input corePkg::regAddr_t traceNum_i
);

    // boot address is presented right after every reset cycle
    assert property (@(posedge clk) reset_i |=> instAddr_i == ResetPc)
        else $error("fetch address is not the reset PC after reset");

    // an entry held by a stall shows up once
    assert property (@(posedge clk) disable iff (reset_i)
                     traceEn_i != 4'b0 |=> !(traceEn_i != 4'b0 && $stable(tracePc_i)))
        else $error("the same trace entry was reported twice");

    assert property (@(posedge clk) disable iff (reset_i) stall_i |=> $stable(instAddr_i))
        else $error("fetch address moved across a stall cycle");

    assert property (@(posedge clk) disable iff (reset_i) traceEn_i != 4'b0 |-> traceNum_i != '0)
        else $error("a write to register zero was traced");

endmodule

bind mipsCore mipsCoreTb_sva #(
    .ResetPc (ResetPc)
) mipsCoreTb_sva_inst (
    .clk        (clk),
    .reset_i    (reset_i),
    .stall_i    (instStall_i),
    .instAddr_i (instAddr_o),
    .traceEn_i  (debugWbRfWen_o),
    .tracePc_i  (debugWbPc_o),
    .traceNum_i (debugWbRfWnum_o)
);

//--- src/mipsCore.sv
module mipsCore #(
    parameter corePkg::word_t ResetPc = 32'hBFC00000
) (
    input  logic              clk,
    input  logic              reset_i,
    output corePkg::word_t    instAddr_o,
    input  corePkg::word_t    instr_i,
    input  logic              instStall_i,
    output corePkg::word_t    debugWbPc_o,
    output logic [3:0]        debugWbRfWen_o,
    output corePkg::regAddr_t debugWbRfWnum_o,
    output corePkg::word_t    debugWbRfWdata_o
);

    corePkg::fetchToDecode_t fetchToDecode;
    corePkg::decodeToExec_t  decodeToExec;
    corePkg::execToWb_t      execToWb;
    corePkg::redirect_t      redirect;
    logic                    rfWrite;
    corePkg::regAddr_t       rfDest;
    corePkg::word_t          rfData;

    fetchStage #(
        .ResetPc (ResetPc)
    ) fetchStage_inst (
        .clk        (clk),
        .reset_i    (reset_i),
        .stall_i    (instStall_i),   // instruction stall freezes every stage
        .redirect_i (redirect),
        .instAddr_o (instAddr_o),
        .instr_i    (instr_i),
        .toDecode_o (fetchToDecode)
    );

    decodeStage decodeStage_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .stall_i     (instStall_i),
        .fromFetch_i (fetchToDecode),
        .wbWrite_i   (rfWrite),
        .wbDest_i    (rfDest),
        .wbData_i    (rfData),
        .toExec_o    (decodeToExec)
    );

    executeStage executeStage_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .stall_i      (instStall_i),
        .fromDecode_i (decodeToExec),
        .wbDest_i     (rfDest),
        .wbWrite_i    (rfWrite),
        .wbData_i     (rfData),
        .redirect_o   (redirect),
        .toWb_o       (execToWb)
    );

    writebackStage writebackStage_inst (
        .clk              (clk),
        .reset_i          (reset_i),
        .stall_i          (instStall_i),
        .fromExec_i       (execToWb),
        .rfWrite_o        (rfWrite),
        .rfDest_o         (rfDest),
        .rfData_o         (rfData),
        .debugWbPc_o      (debugWbPc_o),
        .debugWbRfWen_o   (debugWbRfWen_o),
        .debugWbRfWnum_o  (debugWbRfWnum_o),
        .debugWbRfWdata_o (debugWbRfWdata_o)
    );

endmodule

//--- src/writebackStage.sv
module writebackStage (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               stall_i,
    input  corePkg::execToWb_t fromExec_i,
    output logic               rfWrite_o,
    output corePkg::regAddr_t  rfDest_o,
    output corePkg::word_t     rfData_o,
    output corePkg::word_t     debugWbPc_o,
    output logic [3:0]         debugWbRfWen_o,
    output corePkg::regAddr_t  debugWbRfWnum_o,
    output corePkg::word_t     debugWbRfWdata_o
);

    corePkg::execToWb_t wb;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb.regWrite <= 1'b0;
        end else if (!stall_i) begin
            wb <= fromExec_i;
        end
    end

    assign rfWrite_o = wb.regWrite;   // also feeds execute forwarding
    assign rfDest_o  = wb.dest;
    assign rfData_o  = wb.result;

    // an entry is traced only in the cycle it actually leaves
    assign debugWbPc_o      = wb.pc;
    assign debugWbRfWen_o   = {4{wb.regWrite && !stall_i}};
    assign debugWbRfWnum_o  = wb.dest;
    assign debugWbRfWdata_o = wb.result;

endmodule

//--- src/execute/executeStage.sv
module executeStage (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   stall_i,
    input  corePkg::decodeToExec_t fromDecode_i,
    input  corePkg::regAddr_t      wbDest_i,
    input  logic                   wbWrite_i,
    input  corePkg::word_t         wbData_i,
    output corePkg::redirect_t     redirect_o,
    output corePkg::execToWb_t     toWb_o
);

    corePkg::decodeToExec_t ex;
    corePkg::word_t         rsFwd;
    corePkg::word_t         rtFwd;
    corePkg::word_t         srcB;
    corePkg::word_t         aluResult;
    corePkg::word_t         delaySlotPc;
    corePkg::word_t         branchTarget;
    corePkg::word_t         jumpTarget;
    logic                   taken;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex.valid <= 1'b0;
        end else if (!stall_i) begin
            ex <= fromDecode_i;
        end
    end

    // only the writeback result can be newer than the operands read in decode
    assign rsFwd = (wbWrite_i && wbDest_i != '0 && wbDest_i == ex.rs) ? wbData_i : ex.rsValue;
    assign rtFwd = (wbWrite_i && wbDest_i != '0 && wbDest_i == ex.rt) ? wbData_i : ex.rtValue;
    assign srcB  = ex.ctrl.useImm ? ex.imm : rtFwd;

    alu alu_inst (
        .op_i     (ex.ctrl.aluOp),
        .srcA_i   (rsFwd),
        .srcB_i   (srcB),
        .shamt_i  (ex.shamt),
        .result_o (aluResult)
    );

    assign delaySlotPc  = ex.pc + 32'd4;
    assign branchTarget = delaySlotPc + {ex.imm[29:0], 2'b00};
    assign jumpTarget   = {delaySlotPc[31:28], ex.imm[25:0], 2'b00};

    always_comb begin
        case (ex.ctrl.branchKind)
            corePkg::BrEq:   taken = (rsFwd == rtFwd);
            corePkg::BrNe:   taken = (rsFwd != rtFwd);
            corePkg::BrJump: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    assign redirect_o = '{
        taken:  ex.valid && taken,
        target: (ex.ctrl.branchKind == corePkg::BrJump) ? jumpTarget : branchTarget
    };

    assign toWb_o = '{
        pc:       ex.pc,
        dest:     ex.dest,
        regWrite: ex.valid && ex.ctrl.regWrite,
        result:   aluResult
    };

endmodule

//--- src/execute/alu.sv
module alu (
    input  corePkg::aluOp_t   op_i,
    input  corePkg::word_t    srcA_i,
    input  corePkg::word_t    srcB_i,
    input  corePkg::regAddr_t shamt_i,
    output corePkg::word_t    result_o
);

    logic lessThan;

    assign lessThan = $signed(srcA_i) < $signed(srcB_i);

    always_comb begin
        case (op_i)
            corePkg::AluAdd: result_o = srcA_i + srcB_i;
            corePkg::AluSub: result_o = srcA_i - srcB_i;
            corePkg::AluAnd: result_o = srcA_i & srcB_i;
            corePkg::AluOr:  result_o = srcA_i | srcB_i;
            corePkg::AluXor: result_o = srcA_i ^ srcB_i;
            corePkg::AluSlt: result_o = {31'b0, lessThan};
            corePkg::AluSll: result_o = srcB_i << shamt_i;              // shifts rt
            corePkg::AluLui: result_o = {srcB_i[15:0], 16'b0};
            default:         result_o = '0;
        endcase
    end

endmodule

//--- src/decode/decodeStage.sv
module decodeStage (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    stall_i,
    input  corePkg::fetchToDecode_t fromFetch_i,
    input  logic                    wbWrite_i,
    input  corePkg::regAddr_t       wbDest_i,
    input  corePkg::word_t          wbData_i,
    output corePkg::decodeToExec_t  toExec_o
);

    logic [5:0]        opcode;
    logic [5:0]        funct;
    corePkg::regAddr_t rs;
    corePkg::regAddr_t rt;
    corePkg::regAddr_t rd;
    corePkg::regAddr_t dest;
    corePkg::ctrl_t    decCtrl;
    logic              signExt;
    logic              rdIsDest;
    corePkg::word_t    immExt;
    corePkg::word_t    rsData;
    corePkg::word_t    rtData;

    assign opcode = fromFetch_i.instr[31:26];
    assign rs     = fromFetch_i.instr[25:21];
    assign rt     = fromFetch_i.instr[20:16];
    assign rd     = fromFetch_i.instr[15:11];
    assign funct  = fromFetch_i.instr[5:0];

    always_comb begin
        decCtrl  = '0;   // bubble or unknown opcode runs as a no-op
        signExt  = 1'b0;
        rdIsDest = 1'b0;
        if (fromFetch_i.valid) begin
            case (opcode)
                corePkg::OpSpecial: begin
                    rdIsDest         = 1'b1;
                    decCtrl.regWrite = 1'b1;
                    case (funct)
                        corePkg::FnAddu: decCtrl.aluOp = corePkg::AluAdd;
                        corePkg::FnSubu: decCtrl.aluOp = corePkg::AluSub;
                        corePkg::FnAnd:  decCtrl.aluOp = corePkg::AluAnd;
                        corePkg::FnOr:   decCtrl.aluOp = corePkg::AluOr;
                        corePkg::FnXor:  decCtrl.aluOp = corePkg::AluXor;
                        corePkg::FnSlt:  decCtrl.aluOp = corePkg::AluSlt;
                        corePkg::FnSll:  decCtrl.aluOp = corePkg::AluSll;
                        default:         decCtrl.regWrite = 1'b0;
                    endcase
                end
                corePkg::OpAddiu: begin
                    decCtrl = '{corePkg::AluAdd, 1'b1, 1'b1, corePkg::BrNone};
                    signExt = 1'b1;
                end
                corePkg::OpAndi: decCtrl = '{corePkg::AluAnd, 1'b1, 1'b1, corePkg::BrNone};
                corePkg::OpOri:  decCtrl = '{corePkg::AluOr, 1'b1, 1'b1, corePkg::BrNone};
                corePkg::OpLui:  decCtrl = '{corePkg::AluLui, 1'b1, 1'b1, corePkg::BrNone};
                corePkg::OpBeq: begin
                    decCtrl.branchKind = corePkg::BrEq;
                    signExt            = 1'b1;
                end
                corePkg::OpBne: begin
                    decCtrl.branchKind = corePkg::BrNe;
                    signExt            = 1'b1;
                end
                corePkg::OpJ:    decCtrl.branchKind = corePkg::BrJump;
                default: ;
            endcase
        end
        dest = rdIsDest ? rd : rt;
        if (dest == '0) begin
            decCtrl.regWrite = 1'b0;   // $0 is never written
        end
    end

    assign immExt = (opcode == corePkg::OpJ) ? {6'b0, fromFetch_i.instr[25:0]} :
                    signExt ? {{16{fromFetch_i.instr[15]}}, fromFetch_i.instr[15:0]} :
                              {16'b0, fromFetch_i.instr[15:0]};

    // stalled writeback is retried once the pipe moves again
    regFile regFile_inst (
        .clk      (clk),
        .reset_i  (reset_i),
        .we_i     (wbWrite_i && !stall_i),
        .waddr_i  (wbDest_i),
        .wdata_i  (wbData_i),
        .raddrA_i (rs),
        .raddrB_i (rt),
        .rdataA_o (rsData),
        .rdataB_o (rtData)
    );

    assign toExec_o = '{
        pc:      fromFetch_i.pc,
        ctrl:    decCtrl,
        rsValue: rsData,
        rtValue: rtData,
        imm:     immExt,
        shamt:   fromFetch_i.instr[10:6],
        rs:      rs,
        rt:      rt,
        dest:    dest,
        valid:   fromFetch_i.valid
    };

endmodule

//--- src/decode/regFile.sv
module regFile (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             we_i,
    input  corePkg::regAddr_t waddr_i,
    input  corePkg::word_t   wdata_i,
    input  corePkg::regAddr_t raddrA_i,
    input  corePkg::regAddr_t raddrB_i,
    output corePkg::word_t   rdataA_o,
    output corePkg::word_t   rdataB_o
);

    corePkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // $0 reads zero; a write in flight this cycle is passed straight through
    assign rdataA_o = (raddrA_i == '0) ? '0 :
                      (we_i && waddr_i == raddrA_i) ? wdata_i : regs[raddrA_i];
    assign rdataB_o = (raddrB_i == '0) ? '0 :
                      (we_i && waddr_i == raddrB_i) ? wdata_i : regs[raddrB_i];

endmodule

//--- src/fetch/fetchStage.sv
module fetchStage #(
    parameter corePkg::word_t ResetPc = 32'hBFC00000
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    stall_i,
    input  corePkg::redirect_t      redirect_i,
    output corePkg::word_t          instAddr_o,
    input  corePkg::word_t          instr_i,
    output corePkg::fetchToDecode_t toDecode_o
);

    corePkg::word_t pcReg;
    corePkg::word_t pcPlus4;

    assign pcPlus4    = pcReg + 32'd4;
    assign instAddr_o = pcReg;   // memory answers in the same cycle

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pcReg            <= ResetPc;
            toDecode_o.valid <= 1'b0;
        end else if (!stall_i) begin
            if (redirect_i.taken) begin
                // the word fetched now lies past the delay slot and is dropped
                pcReg            <= redirect_i.target;
                toDecode_o.valid <= 1'b0;
            end else begin
                pcReg      <= pcPlus4;
                toDecode_o <= '{
                    pc:    pcReg,
                    instr: instr_i,
                    valid: 1'b1
                };
            end
        end
    end

endmodule

//--- common/corePkg.sv
package corePkg;

    typedef logic [31:0] word_t;      // data word or byte address
    typedef logic [4:0]  regAddr_t;   // GPR number or shift amount
    typedef logic [3:0]  aluOp_t;
    typedef logic [1:0]  branchKind_t;

    localparam aluOp_t AluAdd = 4'd0;
    localparam aluOp_t AluSub = 4'd1;
    localparam aluOp_t AluAnd = 4'd2;
    localparam aluOp_t AluOr  = 4'd3;
    localparam aluOp_t AluXor = 4'd4;
    localparam aluOp_t AluSlt = 4'd5;   // signed compare
    localparam aluOp_t AluSll = 4'd6;
    localparam aluOp_t AluLui = 4'd7;

    localparam branchKind_t BrNone = 2'd0;
    localparam branchKind_t BrEq   = 2'd1;
    localparam branchKind_t BrNe   = 2'd2;
    localparam branchKind_t BrJump = 2'd3;

    // primary opcodes in instr[31:26]
    localparam logic [5:0] OpSpecial = 6'h00;
    localparam logic [5:0] OpJ       = 6'h02;
    localparam logic [5:0] OpBeq     = 6'h04;
    localparam logic [5:0] OpBne     = 6'h05;
    localparam logic [5:0] OpAddiu   = 6'h09;
    localparam logic [5:0] OpAndi    = 6'h0C;
    localparam logic [5:0] OpOri     = 6'h0D;
    localparam logic [5:0] OpLui     = 6'h0F;

    // SPECIAL function field in instr[5:0]
    localparam logic [5:0] FnSll  = 6'h00;
    localparam logic [5:0] FnAddu = 6'h21;
    localparam logic [5:0] FnSubu = 6'h23;
    localparam logic [5:0] FnAnd  = 6'h24;
    localparam logic [5:0] FnOr   = 6'h25;
    localparam logic [5:0] FnXor  = 6'h26;
    localparam logic [5:0] FnSlt  = 6'h2A;

    typedef struct packed {
        aluOp_t      aluOp;
        logic        useImm;      // srcB from immediate instead of rt
        logic        regWrite;
        branchKind_t branchKind;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
        logic  valid;
    } fetchToDecode_t;

    typedef struct packed {
        word_t    pc;
        ctrl_t    ctrl;
        word_t    rsValue;
        word_t    rtValue;
        word_t    imm;           // holds the 26-bit index for j
        regAddr_t shamt;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t dest;
        logic     valid;
    } decodeToExec_t;

    typedef struct packed {
        word_t    pc;
        regAddr_t dest;
        logic     regWrite;
        word_t    result;
    } execToWb_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage
